// File: Makefile
TOP = tb_mem_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f all.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: all.f
source/pcore_pkg.sv
source/dmem_if.sv
source/mem2wb_if.sv
source/memory.sv
source/dmem.sv
source/writeback.sv
source/mem_subsys_top.sv
tb/mem_checker.sv
tb/tb_mem_subsys.sv

// File: source/dmem.sv
`timescale 1ns/1ps

module dmem (
   input logic     clk,
   dmem_if.dmem_mp port
);
   import pcore_pkg::*;

   logic [XLEN-1:0]       mem_q [DMEM_WORDS];
   logic [DMEM_IDX_W-1:0] word_idx;
   logic [1:0]            byte_off;
   logic [4:0]            lane_shift;
   logic [3:0]            lane_en;
   logic [XLEN-1:0]       wdata_lanes;
   logic                  wr_en;

   assign word_idx   = port.addr[DMEM_IDX_W+1:2];
   assign byte_off   = port.addr[1:0];
   assign lane_shift = {byte_off, 3'b000};   // 8 bits per lane

   // Move mask and data up to the addressed lanes
   assign lane_en     = port.mask << byte_off;
   assign wdata_lanes = port.wdata << lane_shift;

   assign wr_en = ~port.cs_n & ~port.wr_n;

   // Masked byte-lane write
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (lane_en[lane]) begin
               mem_q[word_idx][lane*8 +: 8] <= wdata_lanes[lane*8 +: 8];
            end
         end
      end
   end

   // Combinational read, shifted down to lane 0
   always_comb begin
      if (port.cs_n) begin
         port.rdata = '0;
      end else begin
         port.rdata = mem_q[word_idx] >> lane_shift;
      end
   end

endmodule : dmem

// File: source/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;
   import pcore_pkg::*;

   logic [XLEN-1:0] addr;
   logic [XLEN-1:0] wdata;
   logic            cs_n;    // Request valid while low
   logic            wr_n;    // Store while low
   logic [3:0]      mask;    // Right-aligned byte enables
   logic [XLEN-1:0] rdata;   // Lane 0 aligned, same cycle

   // Memory stage side
   modport mem_mp (
      output addr, wdata, cs_n, wr_n, mask,
      input  rdata
   );

   // Data memory side
   modport dmem_mp (
      input  addr, wdata, cs_n, wr_n, mask,
      output rdata
   );

endinterface : dmem_if

// File: source/mem2wb_if.sv
`timescale 1ns/1ps

interface mem2wb_if;
   import pcore_pkg::*;

   logic [XLEN-1:0]      alu_result;
   logic [XLEN-1:0]      pc;
   logic [RF_ADDR_W-1:0] rd_addr;
   logic [XLEN-1:0]      dmem_data;
   logic [MEM_OPS_W-1:0] load_ops;    // Needed for load extension
   logic [WB_SEL_W-1:0]  rd_wb_sel;
   logic                 rd_wr_req;

   modport src_mp (
      output alu_result, pc, rd_addr, dmem_data,
      output load_ops, rd_wb_sel, rd_wr_req
   );

   modport dst_mp (
      input alu_result, pc, rd_addr, dmem_data,
      input load_ops, rd_wb_sel, rd_wr_req
   );

endinterface : mem2wb_if

// File: source/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
   input  logic                            clk,
   input  logic                            rst_n_i,

   // Execute stage fields
   input  logic [pcore_pkg::XLEN-1:0]      exe_alu_result_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_rs2_data_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_pc_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_instr_i,
   input  logic [pcore_pkg::MEM_OPS_W-1:0] exe_mem_ops_i,
   input  logic [pcore_pkg::WB_SEL_W-1:0]  exe_rd_wb_sel_i,
   input  logic                            exe_rd_wr_req_i,

   // Register file write
   output logic                            rf_wr_o,
   output logic [pcore_pkg::RF_ADDR_W-1:0] rf_addr_o,
   output logic [pcore_pkg::XLEN-1:0]      rf_data_o
);

   // Memory stage to data memory
   dmem_if dmem_bus ();

   // Memory stage to writeback
   mem2wb_if m2w_bus ();

   memory u_memory (
      .exe_alu_result_i (exe_alu_result_i),
      .exe_rs2_data_i   (exe_rs2_data_i),
      .exe_pc_i         (exe_pc_i),
      .exe_instr_i      (exe_instr_i),
      .exe_mem_ops_i    (exe_mem_ops_i),
      .exe_rd_wb_sel_i  (exe_rd_wb_sel_i),
      .exe_rd_wr_req_i  (exe_rd_wr_req_i),
      .dmem             (dmem_bus.mem_mp),
      .wb               (m2w_bus.src_mp)
   );

   dmem u_dmem (
      .clk  (clk),
      .port (dmem_bus.dmem_mp)
   );

   writeback u_writeback (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .wb        (m2w_bus.dst_mp),
      .rf_wr_o   (rf_wr_o),
      .rf_addr_o (rf_addr_o),
      .rf_data_o (rf_data_o)
   );

endmodule : mem_subsys_top

// File: source/memory.sv
`timescale 1ns/1ps

module memory (
   input  logic [pcore_pkg::XLEN-1:0]      exe_alu_result_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_rs2_data_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_pc_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_instr_i,
   input  logic [pcore_pkg::MEM_OPS_W-1:0] exe_mem_ops_i,
   input  logic [pcore_pkg::WB_SEL_W-1:0]  exe_rd_wb_sel_i,
   input  logic                            exe_rd_wr_req_i,
   dmem_if.mem_mp                          dmem,
   mem2wb_if.src_mp                        wb
);
   import pcore_pkg::*;

   logic is_store;
   logic is_load;

   assign is_store = mem_op_is_store(exe_mem_ops_i);
   assign is_load  = mem_op_is_load(exe_mem_ops_i);

   // Request to the data memory
   assign dmem.addr  = exe_alu_result_i;   // Effective address from execute
   assign dmem.wdata = exe_rs2_data_i;
   assign dmem.cs_n  = ~(is_store | is_load);
   assign dmem.wr_n  = ~is_store;

   // Byte mask by access size
   always_comb begin
      case (exe_mem_ops_i)
         MEM_OPS_SB, MEM_OPS_LB, MEM_OPS_LBU: begin
            dmem.mask = 4'b0001;
         end
         MEM_OPS_SH, MEM_OPS_LH, MEM_OPS_LHU: begin
            dmem.mask = 4'b0011;
         end
         MEM_OPS_SW, MEM_OPS_LW: begin
            dmem.mask = 4'b1111;
         end
         default: dmem.mask = 4'b0000;   // None and undefined codes
      endcase
   end

   // Fields carried to writeback
   assign wb.alu_result = exe_alu_result_i;
   assign wb.pc         = exe_pc_i;
   assign wb.rd_addr    = exe_instr_i[11:7];
   assign wb.dmem_data  = dmem.rdata;
   assign wb.load_ops   = exe_mem_ops_i;
   assign wb.rd_wb_sel  = exe_rd_wb_sel_i;
   assign wb.rd_wr_req  = exe_rd_wr_req_i;

endmodule : memory

// File: source/pcore_pkg.sv
package pcore_pkg;

   // Datapath widths
   localparam int XLEN      = 32;
   localparam int RF_ADDR_W = 5;
   localparam int MEM_OPS_W = 4;
   localparam int WB_SEL_W  = 2;

   // Data memory geometry, word indexed by addr[9:2]
   localparam int DMEM_WORDS = 256;
   localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

   // Memory-op codes
   // Stores keep bits 3 and 2 clear, loads set one of them
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_NONE = 4'd0;
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_SB   = 4'd1;
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_SH   = 4'd2;
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_SW   = 4'd3;
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_LB   = 4'd4;
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_LH   = 4'd5;
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_LW   = 4'd6;
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_LBU  = 4'd8;
   localparam logic [MEM_OPS_W-1:0] MEM_OPS_LHU  = 4'd9;

   // Writeback source select
   localparam logic [WB_SEL_W-1:0] WB_SEL_ALU  = 2'd0;
   localparam logic [WB_SEL_W-1:0] WB_SEL_LOAD = 2'd1;
   localparam logic [WB_SEL_W-1:0] WB_SEL_PC4  = 2'd2;

   // Loaded word, already shifted down to lane 0 by the memory
   typedef union packed {
      logic [3:0][7:0]  bytes;    // LB / LBU view
      logic [1:0][15:0] halves;   // LH / LHU view
   } load_word_u;

   // Store codes only
   function automatic logic mem_op_is_store(input logic [MEM_OPS_W-1:0] op);
      return (op == MEM_OPS_SB) || (op == MEM_OPS_SH) || (op == MEM_OPS_SW);
   endfunction

   // Defined load codes only, undefined codes behave as none
   function automatic logic mem_op_is_load(input logic [MEM_OPS_W-1:0] op);
      logic hit;
      hit = 1'b0;
      case (op)
         MEM_OPS_LB, MEM_OPS_LH, MEM_OPS_LW, MEM_OPS_LBU, MEM_OPS_LHU: hit = 1'b1;
         default: hit = 1'b0;
      endcase
      return hit;
   endfunction

endpackage : pcore_pkg

// File: source/writeback.sv
`timescale 1ns/1ps

module writeback (
   input  logic                            clk,
   input  logic                            rst_n_i,
   mem2wb_if.dst_mp                        wb,
   output logic                            rf_wr_o,
   output logic [pcore_pkg::RF_ADDR_W-1:0] rf_addr_o,
   output logic [pcore_pkg::XLEN-1:0]      rf_data_o
);
   import pcore_pkg::*;

   logic [XLEN-1:0]      alu_result_q;
   logic [XLEN-1:0]      pc_q;
   logic [RF_ADDR_W-1:0] rd_addr_q;
   logic [XLEN-1:0]      dmem_data_q;
   logic [MEM_OPS_W-1:0] load_ops_q;
   logic [WB_SEL_W-1:0]  rd_wb_sel_q;
   logic                 rd_wr_req_q;

   load_word_u           ld_word;
   logic [XLEN-1:0]      load_ext;

   // MEM/WB pipeline register
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         alu_result_q <= '0;
         pc_q         <= '0;
         rd_addr_q    <= '0;
         dmem_data_q  <= '0;
         load_ops_q   <= MEM_OPS_NONE;
         rd_wb_sel_q  <= WB_SEL_ALU;
         rd_wr_req_q  <= 1'b0;
      end else begin
         alu_result_q <= wb.alu_result;
         pc_q         <= wb.pc;
         rd_addr_q    <= wb.rd_addr;
         dmem_data_q  <= wb.dmem_data;
         load_ops_q   <= wb.load_ops;
         rd_wb_sel_q  <= wb.rd_wb_sel;
         rd_wr_req_q  <= wb.rd_wr_req;
      end
   end

   assign ld_word = dmem_data_q;

   // Sign or zero extension of the lane 0 data
   always_comb begin
      case (load_ops_q)
         MEM_OPS_LB:  load_ext = {{(XLEN-8){ld_word.bytes[0][7]}}, ld_word.bytes[0]};
         MEM_OPS_LBU: load_ext = {{(XLEN-8){1'b0}}, ld_word.bytes[0]};
         MEM_OPS_LH:  load_ext = {{(XLEN-16){ld_word.halves[0][15]}}, ld_word.halves[0]};
         MEM_OPS_LHU: load_ext = {{(XLEN-16){1'b0}}, ld_word.halves[0]};
         default:     load_ext = ld_word;   // LW passes the whole word
      endcase
   end

   // Writeback source
   always_comb begin
      case (rd_wb_sel_q)
         WB_SEL_LOAD: rf_data_o = load_ext;
         WB_SEL_PC4:  rf_data_o = pc_q + XLEN'(4);   // Link address
         default:     rf_data_o = alu_result_q;
      endcase
   end

   // x0 is never written
   assign rf_wr_o   = rd_wr_req_q & (|rd_addr_q);
   assign rf_addr_o = rd_addr_q;

endmodule : writeback

// File: tb/mem_checker.sv
`timescale 1ns/1ps

module mem_checker (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_alu_result_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_rs2_data_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_pc_i,
   input  logic [pcore_pkg::XLEN-1:0]      exe_instr_i,
   input  logic [pcore_pkg::MEM_OPS_W-1:0] exe_mem_ops_i,
   input  logic [pcore_pkg::WB_SEL_W-1:0]  exe_rd_wb_sel_i,
   input  logic                            exe_rd_wr_req_i,
   input  logic                            rf_wr_o,
   input  logic [pcore_pkg::RF_ADDR_W-1:0] rf_addr_o,
   input  logic [pcore_pkg::XLEN-1:0]      rf_data_o,
   output int                              error_count_o,
   output int                              check_count_o
);
   import pcore_pkg::*;

   logic [XLEN-1:0]      model_mem [DMEM_WORDS];
   logic                 exp_valid = 1'b0;
   logic                 exp_wr;
   logic [RF_ADDR_W-1:0] exp_addr;
   logic [XLEN-1:0]      exp_data;
   int                   errors = 0;
   int                   checks = 0;

   assign error_count_o = errors;
   assign check_count_o = checks;

   // Value a load writes back, lane picked by the byte offset
   function automatic logic [XLEN-1:0] load_value(input logic [3:0] op,
                                                  input logic [XLEN-1:0] word,
                                                  input logic [1:0] off);
      logic [7:0]  lane_byte;
      logic [15:0] lane_half;
      lane_byte = word[{off, 3'b000} +: 8];
      lane_half = word[{off[1], 4'b0000} +: 16];
      case (op)
         MEM_OPS_LB:  return {{24{lane_byte[7]}}, lane_byte};
         MEM_OPS_LBU: return {24'h0, lane_byte};
         MEM_OPS_LH:  return {{16{lane_half[15]}}, lane_half};
         MEM_OPS_LHU: return {16'h0, lane_half};
         MEM_OPS_LW:  return word;
         default:     return '0;
      endcase
   endfunction

   // Word after a store, other lanes untouched
   function automatic logic [XLEN-1:0] store_merge(input logic [3:0] op,
                                                   input logic [XLEN-1:0] old_word,
                                                   input logic [XLEN-1:0] data,
                                                   input logic [1:0] off);
      logic [XLEN-1:0] word;
      word = old_word;
      case (op)
         MEM_OPS_SB: word[{off, 3'b000} +: 8]     = data[7:0];
         MEM_OPS_SH: word[{off[1], 4'b0000} +: 16] = data[15:0];
         MEM_OPS_SW: word = data;
         default:    word = old_word;   // Loads and undefined codes
      endcase
      return word;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Fail at %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
         errors = errors + 1;
      end
   endtask

   // Falling edge, inputs and outputs are both stable here
   always @(negedge clk) begin
      logic [7:0] idx;
      if (exp_valid) begin
         checks = checks + 1;
         compare_value("rf_wr_o", 32'(exp_wr), 32'(rf_wr_o));
         compare_value("rf_addr_o", 32'(exp_addr), 32'(rf_addr_o));
         compare_value("rf_data_o", exp_data, rf_data_o);
      end
      idx = exe_alu_result_i[9:2];
      if (!rst_n_i) begin
         exp_wr   = 1'b0;   // Writeback register is cleared
         exp_addr = '0;
         exp_data = '0;
      end else begin
         exp_addr = exe_instr_i[11:7];
         exp_wr   = exe_rd_wr_req_i && (exp_addr != 5'd0);
         case (exe_rd_wb_sel_i)
            WB_SEL_LOAD: exp_data = load_value(exe_mem_ops_i, model_mem[idx],
                                               exe_alu_result_i[1:0]);
            WB_SEL_PC4:  exp_data = exe_pc_i + 32'd4;
            default:     exp_data = exe_alu_result_i;
         endcase
         model_mem[idx] = store_merge(exe_mem_ops_i, model_mem[idx], exe_rs2_data_i,
                                      exe_alu_result_i[1:0]);
      end
      exp_valid = 1'b1;
   end

endmodule : mem_checker

// File: tb/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
   import pcore_pkg::*;

   localparam int N_RANDOM   = 400;
   localparam int EDGE_LIMIT = 100;   // ns allowed between rising edges
   localparam int DONE_LIMIT = 200;   // ns allowed for the last checks

   logic                 clk;
   logic                 rst_n_i;
   logic [XLEN-1:0]      exe_alu_result_i;
   logic [XLEN-1:0]      exe_rs2_data_i;
   logic [XLEN-1:0]      exe_pc_i;
   logic [XLEN-1:0]      exe_instr_i;
   logic [MEM_OPS_W-1:0] exe_mem_ops_i;
   logic [WB_SEL_W-1:0]  exe_rd_wb_sel_i;
   logic                 exe_rd_wr_req_i;
   logic                 rf_wr_o;
   logic [RF_ADDR_W-1:0] rf_addr_o;
   logic [XLEN-1:0]      rf_data_o;

   int     error_count;
   int     check_count;
   int     timeout_count = 0;
   int     edge_count    = 0;
   time    edge_time     = 0;
   logic   timed_out     = 1'b0;
   integer seed          = 76;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      edge_count = edge_count + 1;
      edge_time  = $time;
   end

   mem_subsys_top UUT (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .exe_alu_result_i (exe_alu_result_i),
      .exe_rs2_data_i   (exe_rs2_data_i),
      .exe_pc_i         (exe_pc_i),
      .exe_instr_i      (exe_instr_i),
      .exe_mem_ops_i    (exe_mem_ops_i),
      .exe_rd_wb_sel_i  (exe_rd_wb_sel_i),
      .exe_rd_wr_req_i  (exe_rd_wr_req_i),
      .rf_wr_o          (rf_wr_o),
      .rf_addr_o        (rf_addr_o),
      .rf_data_o        (rf_data_o)
   );

   mem_checker u_mem_checker (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .exe_alu_result_i (exe_alu_result_i),
      .exe_rs2_data_i   (exe_rs2_data_i),
      .exe_pc_i         (exe_pc_i),
      .exe_instr_i      (exe_instr_i),
      .exe_mem_ops_i    (exe_mem_ops_i),
      .exe_rd_wb_sel_i  (exe_rd_wb_sel_i),
      .exe_rd_wr_req_i  (exe_rd_wr_req_i),
      .rf_wr_o          (rf_wr_o),
      .rf_addr_o        (rf_addr_o),
      .rf_data_o        (rf_data_o),
      .error_count_o    (error_count),
      .check_count_o    (check_count)
   );

   // Returns once a rising edge has been seen, or the timeout hit
   task automatic wait_for_edge;
      int start;
      int waited;
      start  = edge_count;
      waited = 0;
      while (!timed_out && edge_count == start) begin
         if (waited >= EDGE_LIMIT) begin
            $display("Timeout at %0t: no rising clock edge within %0d ns", $time, EDGE_LIMIT);
            timed_out     = 1'b1;
            timeout_count = timeout_count + 1;
         end else begin
            #1;
            waited++;
         end
      end
   endtask

   // One operation per cycle applied 2 ns after the edge
   task automatic drive_op(input logic [3:0] op, input logic [7:0] idx, input logic [1:0] off,
                           input logic [1:0] sel, input logic [4:0] rd, input logic req,
                           input logic [31:0] data);
      logic [31:0] upper_rnd;
      logic [31:0] pc_rnd;
      logic [31:0] instr_rnd;
      upper_rnd = $random(seed);
      pc_rnd    = $random(seed);
      instr_rnd = $random(seed);
      wait_for_edge();
      if (!timed_out) begin
         #(edge_time + 2 - $time);
         exe_alu_result_i = {upper_rnd[31:10], idx, off};   // Word index in bits 9:2
         exe_rs2_data_i   = data;
         exe_pc_i         = {pc_rnd[31:2], 2'b00};
         exe_instr_i      = {instr_rnd[31:12], rd, instr_rnd[6:0]};
         exe_mem_ops_i    = op;
         exe_rd_wb_sel_i  = sel;
         exe_rd_wr_req_i  = req;
      end
   endtask

   initial begin
      logic [31:0] rnd;
      logic [31:0] data;
      logic [3:0]  op;
      logic [7:0]  idx;
      logic [7:0]  last_idx;
      logic [1:0]  off;
      logic [1:0]  sel;
      int          target;
      int          waited;

      rst_n_i          = 1'b0;
      exe_alu_result_i = '0;
      exe_rs2_data_i   = '0;
      exe_pc_i         = '0;
      exe_instr_i      = '0;
      exe_mem_ops_i    = MEM_OPS_NONE;
      exe_rd_wb_sel_i  = WB_SEL_ALU;
      exe_rd_wr_req_i  = 1'b0;
      last_idx         = 8'd0;

      // Live write requests in reset, the register must stay cleared
      for (int i = 0; i < 4; i++) begin
         drive_op(MEM_OPS_NONE, 8'd0, 2'd0, WB_SEL_PC4, 5'd9, 1'b1, 32'd0);
      end
      drive_op(MEM_OPS_NONE, 8'd0, 2'd0, WB_SEL_ALU, 5'd0, 1'b0, 32'd0);
      rst_n_i = 1'b1;

      // Warm-up stores give every word that is loaded later a defined value
      for (int k = 0; k < 32; k++) begin
         rnd  = $random(seed);
         data = $random(seed);
         drive_op(MEM_OPS_SW, {k[4:0], 3'b000}, 2'd0, WB_SEL_ALU, rnd[4:0], rnd[5], data);
      end

      // Store then load back, then partial stores and the four extensions
      drive_op(MEM_OPS_SW,  8'd16, 2'd0, WB_SEL_ALU,  5'd1, 1'b1, 32'h8bad_f00d);
      drive_op(MEM_OPS_LW,  8'd16, 2'd0, WB_SEL_LOAD, 5'd2, 1'b1, 32'd0);
      drive_op(MEM_OPS_SB,  8'd16, 2'd1, WB_SEL_ALU,  5'd3, 1'b1, 32'h0000_00f0);
      drive_op(MEM_OPS_SH,  8'd16, 2'd2, WB_SEL_PC4,  5'd4, 1'b1, 32'h0000_8001);
      drive_op(MEM_OPS_LW,  8'd16, 2'd0, WB_SEL_LOAD, 5'd5, 1'b1, 32'd0);
      drive_op(MEM_OPS_LB,  8'd16, 2'd1, WB_SEL_LOAD, 5'd6, 1'b1, 32'd0);
      drive_op(MEM_OPS_LBU, 8'd16, 2'd1, WB_SEL_LOAD, 5'd7, 1'b1, 32'd0);
      drive_op(MEM_OPS_LH,  8'd16, 2'd2, WB_SEL_LOAD, 5'd8, 1'b1, 32'd0);
      drive_op(MEM_OPS_LHU, 8'd16, 2'd2, WB_SEL_LOAD, 5'd0, 1'b1, 32'd0);

      for (int n = 0; n < N_RANDOM; n++) begin
         rnd  = $random(seed);
         data = $random(seed);
         op   = rnd[3:0];
         idx  = (rnd[5:4] == 2'b00) ? last_idx : {rnd[10:6], 3'b000};   // Often the same word
         case (op)
            MEM_OPS_SH, MEM_OPS_LH, MEM_OPS_LHU: off = {rnd[11], 1'b0};
            MEM_OPS_SW, MEM_OPS_LW:              off = 2'd0;
            default:                             off = rnd[12:11];
         endcase
         case (op)
            MEM_OPS_LB, MEM_OPS_LH, MEM_OPS_LW, MEM_OPS_LBU, MEM_OPS_LHU: begin
               sel = (rnd[14:13] == 2'd3) ? WB_SEL_LOAD : rnd[14:13];
            end
            default: sel = rnd[13] ? WB_SEL_PC4 : WB_SEL_ALU;   // Load data only for loads
         endcase
         last_idx = idx;
         drive_op(op, idx, off, sel, rnd[19:15], rnd[20], data);
      end
      drive_op(MEM_OPS_NONE, 8'd0, 2'd0, WB_SEL_ALU, 5'd0, 1'b0, 32'd0);

      // The checker compares each op one cycle after it was applied
      target = check_count + 2;
      waited = 0;
      while (!timed_out && check_count < target) begin
         if (waited >= DONE_LIMIT) begin
            $display("Timeout at %0t: checker did not finish the last comparisons", $time);
            timed_out     = 1'b1;
            timeout_count = timeout_count + 1;
         end else begin
            #1;
            waited++;
         end
      end

      $display("Errors: %0d mismatches, %0d timeouts, %0d cycles checked",
               error_count, timeout_count, check_count);
      if (timed_out || error_count != 0) begin
         $display("Test failed");
      end else begin
         $display("Test passed");
      end
      $finish;
   end

endmodule : tb_mem_subsys
